//--- alu_pipe.sv
// Issue, execute and common data bus
module alu_pipe (
    input  logic                             clock,
    input  logic                             arst_n,
    input  logic                             issue_en,
    input  rename_pkg::alu_op_t              issue_op,
    input  logic [rename_pkg::xlen-1:0]      issue_a, issue_b,
    input  logic [rename_pkg::tag_w-1:0]     issue_tag,
    input  logic [rename_pkg::rob_idx_w-1:0] issue_rob_idx,
    output logic                             cdb_en,
    output logic [rename_pkg::tag_w-1:0]     cdb_tag,
    output logic [rename_pkg::xlen-1:0]      cdb_data,
    output logic [rename_pkg::rob_idx_w-1:0] cdb_rob_idx
);

    // Issue register
    logic                             iss_valid;
    rename_pkg::alu_op_t              iss_op;
    logic [rename_pkg::xlen-1:0]      iss_a, iss_b, result;
    logic [rename_pkg::tag_w-1:0]     iss_tag;
    logic [rename_pkg::rob_idx_w-1:0] iss_rob_idx;

    //////////////////////////////
    // ALU
    //////////////////////////////

    // Shifts use the low five bits of b
    always_comb begin
        case (iss_op)
            rename_pkg::alu_add:  result = iss_a + iss_b;
            rename_pkg::alu_sub:  result = iss_a - iss_b;
            rename_pkg::alu_sll:  result = iss_a << iss_b[4:0];
            rename_pkg::alu_slt:  result = rename_pkg::xlen'($signed(iss_a) < $signed(iss_b));
            rename_pkg::alu_sltu: result = rename_pkg::xlen'(iss_a < iss_b);
            rename_pkg::alu_xor:  result = iss_a ^ iss_b;
            rename_pkg::alu_srl:  result = iss_a >> iss_b[4:0];
            rename_pkg::alu_sra:  result = $signed(iss_a) >>> iss_b[4:0];
            rename_pkg::alu_or:   result = iss_a | iss_b;
            rename_pkg::alu_and:  result = iss_a & iss_b;
            default:              result = '0;
        endcase
    end

    //////////////////////////////
    // Pipeline registers
    //////////////////////////////

    // Valid bits
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            iss_valid <= 1'b0;
            cdb_en    <= 1'b0;
        end else begin
            iss_valid <= issue_en;
            cdb_en    <= iss_valid;
        end
    end

    // Payload, execute stage drives the bus
    always_ff @(posedge clock) begin
        if (issue_en) begin
            iss_op      <= issue_op;
            iss_a       <= issue_a;
            iss_b       <= issue_b;
            iss_tag     <= issue_tag;
            iss_rob_idx <= issue_rob_idx;
        end
        if (iss_valid) begin
            cdb_tag     <= iss_tag;
            cdb_data    <= result;
            cdb_rob_idx <= iss_rob_idx;
        end
    end

endmodule

//--- dispatch.sv
// Decode and dispatch
module dispatch (
    input  logic                              inst_valid,
    input  logic [31:0]                       inst,
    input  logic [rename_pkg::tag_w-1:0]      src1_tag, src2_tag, old_tag,
    input  logic                              src1_ready, src2_ready,
    input  logic [rename_pkg::xlen-1:0]       src1_value, src2_value,
    input  logic                              fl_empty, rob_full,
    input  logic [rename_pkg::rob_idx_w-1:0]  rob_tail_idx,
    output logic                              inst_ready,
    output logic [rename_pkg::arch_idx_w-1:0] rs1_idx, rs2_idx,
    output logic                              rename_en,
    output logic [rename_pkg::arch_idx_w-1:0] rename_idx,
    output logic                              pop_en,
    input  logic [rename_pkg::tag_w-1:0]      new_tag,
    output logic                              alloc_en, alloc_wr,
    output logic [rename_pkg::arch_idx_w-1:0] alloc_idx,
    output logic [rename_pkg::tag_w-1:0]      alloc_old_tag,
    output logic                              issue_en,
    output rename_pkg::alu_op_t               issue_op,
    output logic [rename_pkg::xlen-1:0]       issue_a, issue_b,
    output logic [rename_pkg::tag_w-1:0]      issue_tag,
    output logic [rename_pkg::rob_idx_w-1:0]  issue_rob_idx
);

    rename_pkg::inst_word_t iw;
    logic is_op, is_imm, is_shift, alt_ok, f7_ok, legal, wr, srcs_ok, accept;

    assign iw = inst;

    //////////////////////////////
    // Decode
    //////////////////////////////

    // Opcode class from the immediate view, funct7 from the register view
    assign is_op    = iw.r.opcode == rename_pkg::opcode_op;
    assign is_imm   = iw.i.opcode == rename_pkg::opcode_op_imm;
    assign is_shift = iw.r.funct3 == 3'b001 || iw.r.funct3 == 3'b101;
    // Alternate funct7 only for SUB and the arithmetic shifts
    assign alt_ok   = iw.r.funct3 == 3'b101 || (is_op && iw.r.funct3 == 3'b000);
    assign f7_ok    = iw.r.funct7 == 7'h00 || (iw.r.funct7 == 7'h20 && alt_ok);
    // Non-shift immediates use the whole upper field as data
    assign legal    = is_op ? f7_ok : (is_imm && (!is_shift || f7_ok));
    // x0 target gives a non-writing entry
    assign wr       = legal && iw.r.rd != '0;

    always_comb begin
        case (iw.r.funct3)
            3'b000:  issue_op = (is_op && iw.r.funct7[5]) ? rename_pkg::alu_sub
                                                           : rename_pkg::alu_add;
            3'b001:  issue_op = rename_pkg::alu_sll;
            3'b010:  issue_op = rename_pkg::alu_slt;
            3'b011:  issue_op = rename_pkg::alu_sltu;
            3'b100:  issue_op = rename_pkg::alu_xor;
            3'b101:  issue_op = iw.r.funct7[5] ? rename_pkg::alu_sra : rename_pkg::alu_srl;
            3'b110:  issue_op = rename_pkg::alu_or;
            default: issue_op = rename_pkg::alu_and;
        endcase
    end

    //////////////////////////////
    // Readiness and handshake
    //////////////////////////////

    // No-ops read nothing, immediates skip rs2
    assign srcs_ok    = !legal || (src1_ready && (is_imm || src2_ready));
    assign inst_ready = !rob_full && !(wr && fl_empty) && srcs_ok;
    assign accept     = inst_valid && inst_ready;

    // Source lookups
    assign rs1_idx = iw.r.rs1;
    assign rs2_idx = iw.r.rs2;

    // Rename and free list pop only for writers
    assign rename_en  = accept && wr;
    assign pop_en     = accept && wr;
    assign rename_idx = iw.i.rd;

    // Every accepted instruction takes a ROB slot
    assign alloc_en      = accept;
    assign alloc_wr      = wr;
    assign alloc_idx     = iw.i.rd;
    assign alloc_old_tag = old_tag;

    // Issue in order, non-writers target tag 0 which PRF ignores
    assign issue_en      = accept;
    assign issue_a       = src1_value;
    assign issue_b       = is_imm ? {{20{iw.i.imm12[11]}}, iw.i.imm12} : src2_value;
    assign issue_tag     = wr ? new_tag : '0;
    assign issue_rob_idx = rob_tail_idx;

endmodule

//--- free_list.sv
// Physical tag free list
module free_list (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic                         pop_en,
    output logic [rename_pkg::tag_w-1:0] new_tag,
    output logic                         fl_empty,
    input  logic                         push_en,
    input  logic [rename_pkg::tag_w-1:0] push_tag
);

    // 32 slots, pointers wrap on their own
    logic [rename_pkg::tag_w-1:0] slots [rename_pkg::phys_regs - rename_pkg::arch_regs];
    logic [rename_pkg::tag_w-2:0] head, tail;
    // Holds 0 to 32
    logic [rename_pkg::tag_w-1:0] count;

    assign new_tag  = slots[head];
    assign fl_empty = count == '0;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= rename_pkg::tag_w'(rename_pkg::phys_regs - rename_pkg::arch_regs);
            // Upper half of the tags starts free
            for (int i = 0; i < rename_pkg::phys_regs - rename_pkg::arch_regs; i++) begin
                slots[i] <= rename_pkg::tag_w'(rename_pkg::arch_regs + i);
            end
        end else begin
            if (pop_en) begin
                head <= head + 1'b1;
            end
            // Retired old mapping
            if (push_en) begin
                slots[tail] <= push_tag;
                tail        <= tail + 1'b1;
            end
            count <= count + rename_pkg::tag_w'(push_en) - rename_pkg::tag_w'(pop_en);
        end
    end

endmodule

//--- map_table.sv
// Speculative register map
module map_table (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic [rename_pkg::arch_idx_w-1:0] rs1_idx, rs2_idx,
    output logic [rename_pkg::tag_w-1:0]      src1_tag, src2_tag,
    input  logic                              rename_en,
    input  logic [rename_pkg::arch_idx_w-1:0] rename_idx,
    input  logic [rename_pkg::tag_w-1:0]      new_tag,
    output logic [rename_pkg::tag_w-1:0]      old_tag
);

    // One physical tag per architectural register
    logic [rename_pkg::tag_w-1:0] map [rename_pkg::arch_regs];

    // Source lookups
    assign src1_tag = map[rs1_idx];
    assign src2_tag = map[rs2_idx];
    // Mapping about to be replaced, freed at retirement
    assign old_tag  = map[rename_idx];

    // Identity map at reset, xN lives in tag N
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rename_pkg::arch_regs; i++) begin
                map[i] <= rename_pkg::tag_w'(i);
            end
        end else if (rename_en) begin
            map[rename_idx] <= new_tag;
        end
    end

endmodule

//--- prf.sv
// Physical register file
module prf (
    input  logic                         clock,
    input  logic                         arst_n,
    input  logic [rename_pkg::tag_w-1:0] src1_tag, src2_tag,
    output logic [rename_pkg::xlen-1:0]  src1_value, src2_value,
    output logic                         src1_ready, src2_ready,
    input  logic                         clear_en,
    input  logic [rename_pkg::tag_w-1:0] clear_tag,
    input  logic                         cdb_en,
    input  logic [rename_pkg::tag_w-1:0] cdb_tag,
    input  logic [rename_pkg::xlen-1:0]  cdb_data,
    input  logic [rename_pkg::tag_w-1:0] retire_tag,
    output logic [rename_pkg::xlen-1:0]  retire_data
);

    logic [rename_pkg::xlen-1:0]      values [rename_pkg::phys_regs];
    logic [rename_pkg::phys_regs-1:0] ready;
    logic                             hit1, hit2;

    //////////////////////////////
    // Reads
    //////////////////////////////

    // Same-cycle bus match, tag 0 never hits
    assign hit1 = cdb_en && cdb_tag == src1_tag && src1_tag != '0;
    assign hit2 = cdb_en && cdb_tag == src2_tag && src2_tag != '0;

    // Operands with bypass
    assign src1_ready = ready[src1_tag] || hit1;
    assign src2_ready = ready[src2_tag] || hit2;
    assign src1_value = hit1 ? cdb_data : values[src1_tag];
    assign src2_value = hit2 ? cdb_data : values[src2_tag];

    // Retirement read, value already written a cycle earlier
    assign retire_data = values[retire_tag];

    //////////////////////////////
    // Writes
    //////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rename_pkg::phys_regs; i++) begin
                values[i] <= '0;
                // Identity-mapped tags hold committed zeros
                ready[i]  <= i < rename_pkg::arch_regs;
            end
        end else begin
            // Fresh destination waits for its result
            if (clear_en && clear_tag != '0) begin
                ready[clear_tag] <= 1'b0;
            end
            // Tag 0 stays zero
            if (cdb_en && cdb_tag != '0) begin
                values[cdb_tag] <= cdb_data;
                ready[cdb_tag]  <= 1'b1;
            end
        end
    end

endmodule

//--- rename_core.sv
// Register rename core top level
module rename_core (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              inst_valid,
    input  logic [31:0]                       inst,
    output logic                              inst_ready,
    output logic                              commit_valid,
    output logic                              commit_wr,
    output logic [rename_pkg::arch_idx_w-1:0] commit_idx,
    output logic [rename_pkg::xlen-1:0]       commit_data
);

    //////////////////////////////
    // Wires
    //////////////////////////////

    // Map table lookups
    logic [rename_pkg::arch_idx_w-1:0] rs1_idx, rs2_idx, rename_idx, alloc_idx;
    logic [rename_pkg::tag_w-1:0]      src1_tag, src2_tag, old_tag, new_tag;
    logic                              rename_en;

    // Operand reads
    logic [rename_pkg::xlen-1:0] src1_value, src2_value;
    logic                        src1_ready, src2_ready;

    // Free list and ROB
    logic                              fl_empty, pop_en, free_en;
    logic [rename_pkg::tag_w-1:0]      free_tag, retire_tag, alloc_old_tag;
    logic                              rob_full, alloc_en, alloc_wr;
    logic [rename_pkg::rob_idx_w-1:0]  rob_tail_idx;
    logic [rename_pkg::xlen-1:0]       retire_data;

    // Issue and common data bus
    logic                             issue_en, cdb_en;
    rename_pkg::alu_op_t              issue_op;
    logic [rename_pkg::xlen-1:0]      issue_a, issue_b, cdb_data;
    logic [rename_pkg::tag_w-1:0]     issue_tag, cdb_tag;
    logic [rename_pkg::rob_idx_w-1:0] issue_rob_idx, cdb_rob_idx;

    //////////////////////////////
    // Front end
    //////////////////////////////

    dispatch u_dispatch (
        .inst_valid    (inst_valid),
        .inst          (inst),
        .src1_tag      (src1_tag),
        .src2_tag      (src2_tag),
        .src1_ready    (src1_ready),
        .src2_ready    (src2_ready),
        .src1_value    (src1_value),
        .src2_value    (src2_value),
        .old_tag       (old_tag),
        .fl_empty      (fl_empty),
        .rob_full      (rob_full),
        .rob_tail_idx  (rob_tail_idx),
        .inst_ready    (inst_ready),
        .rs1_idx       (rs1_idx),
        .rs2_idx       (rs2_idx),
        .rename_en     (rename_en),
        .rename_idx    (rename_idx),
        .pop_en        (pop_en),
        .new_tag       (new_tag),
        .alloc_en      (alloc_en),
        .alloc_wr      (alloc_wr),
        .alloc_idx     (alloc_idx),
        .alloc_old_tag (alloc_old_tag),
        .issue_en      (issue_en),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_tag     (issue_tag),
        .issue_rob_idx (issue_rob_idx)
    );

    map_table u_map_table (
        .clock      (clock),
        .arst_n     (arst_n),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .src1_tag   (src1_tag),
        .src2_tag   (src2_tag),
        .rename_en  (rename_en),
        .rename_idx (rename_idx),
        .new_tag    (new_tag),
        .old_tag    (old_tag)
    );

    // Old tags come back on retirement
    free_list u_free_list (
        .clock    (clock),
        .arst_n   (arst_n),
        .pop_en   (pop_en),
        .new_tag  (new_tag),
        .fl_empty (fl_empty),
        .push_en  (free_en),
        .push_tag (free_tag)
    );

    //////////////////////////////
    // Back end
    //////////////////////////////

    rob u_rob (
        .clock         (clock),
        .arst_n        (arst_n),
        .alloc_en      (alloc_en),
        .alloc_wr      (alloc_wr),
        .alloc_idx     (alloc_idx),
        .alloc_tag     (new_tag),
        .alloc_old_tag (alloc_old_tag),
        .rob_full      (rob_full),
        .rob_tail_idx  (rob_tail_idx),
        .cdb_en        (cdb_en),
        .cdb_rob_idx   (cdb_rob_idx),
        .retire_tag    (retire_tag),
        .retire_data   (retire_data),
        .free_en       (free_en),
        .free_tag      (free_tag),
        .commit_valid  (commit_valid),
        .commit_wr     (commit_wr),
        .commit_idx    (commit_idx),
        .commit_data   (commit_data)
    );

    // New destination tag goes not ready on rename
    prf u_prf (
        .clock       (clock),
        .arst_n      (arst_n),
        .src1_tag    (src1_tag),
        .src2_tag    (src2_tag),
        .src1_value  (src1_value),
        .src2_value  (src2_value),
        .src1_ready  (src1_ready),
        .src2_ready  (src2_ready),
        .clear_en    (rename_en),
        .clear_tag   (new_tag),
        .cdb_en      (cdb_en),
        .cdb_tag     (cdb_tag),
        .cdb_data    (cdb_data),
        .retire_tag  (retire_tag),
        .retire_data (retire_data)
    );

    alu_pipe u_alu_pipe (
        .clock         (clock),
        .arst_n        (arst_n),
        .issue_en      (issue_en),
        .issue_op      (issue_op),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_tag     (issue_tag),
        .issue_rob_idx (issue_rob_idx),
        .cdb_en        (cdb_en),
        .cdb_tag       (cdb_tag),
        .cdb_data      (cdb_data),
        .cdb_rob_idx   (cdb_rob_idx)
    );

endmodule

//--- rename_core_assertions.sv
// Rename core port assertions
module rename_core_assertions (
    input logic       clock,
    input logic       arst_n,
    input logic       inst_ready,
    input logic       commit_valid,
    input logic       commit_wr,
    input logic [4:0] commit_idx
);

    timeunit 1ns;
    timeprecision 100ps;

    // Count of failed checks
    int failures = 0;

    // A write is only reported with a commit
    property wr_with_valid;
        @(posedge clock) disable iff (!arst_n) commit_wr |-> commit_valid;
    endproperty

    // x0 is never a committed target
    property wr_idx_nonzero;
        @(posedge clock) disable iff (!arst_n) commit_wr |-> commit_idx != '0;
    endproperty

    // Handshake output always resolved
    property ready_known;
        @(posedge clock) disable iff (!arst_n) !$isunknown(inst_ready);
    endproperty

    wr_with_valid_a: assert property (wr_with_valid)
        else begin
            failures++;
            $error("commit_wr high without commit_valid");
        end
    wr_idx_nonzero_a: assert property (wr_idx_nonzero)
        else begin
            failures++;
            $error("commit_wr high with commit_idx of zero");
        end
    ready_known_a: assert property (ready_known)
        else begin
            failures++;
            $error("inst_ready is unknown after reset");
        end

endmodule

bind rename_core rename_core_assertions u_assertions (
    .clock        (clock),
    .arst_n       (arst_n),
    .inst_ready   (inst_ready),
    .commit_valid (commit_valid),
    .commit_wr    (commit_wr),
    .commit_idx   (commit_idx)
);

//--- rename_core_tb.sv
// Rename core testbench
module rename_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_rows     = 80;
    localparam int reset_cycles = 4;

    logic        clock, arst_n, inst_valid, inst_ready;
    logic        commit_valid, commit_wr;
    logic [31:0] inst, commit_data;
    logic [4:0]  commit_idx;

    // Stimulus table, one row per instruction
    string       row_name [max_rows];
    logic [31:0] row_word [max_rows];
    logic        row_wr   [max_rows];
    logic [4:0]  row_idx  [max_rows];
    logic [31:0] row_data [max_rows];
    int          row_count   = 0;
    bit          table_built = 1'b0;

    int          errors  = 0;
    int          commits = 0;
    logic [31:0] lcg_state = 32'd51;

    tb_clock u_clock (.clock(clock), .arst_n(arst_n));

    rename_core uut (
        .clock        (clock),
        .arst_n       (arst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_ready   (inst_ready),
        .commit_valid (commit_valid),
        .commit_wr    (commit_wr),
        .commit_idx   (commit_idx),
        .commit_data  (commit_data)
    );

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Idle gap of 0 to 3 cycles
    function automatic int unsigned next_gap();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) % 4;
    endfunction

    // OP class encoder
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    // OP-IMM class encoder
    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic add_row(input string name, input logic [31:0] word, input logic wr,
                           input logic [4:0] idx, input logic [31:0] data);
        row_name[row_count] = name;
        row_word[row_count] = word;
        row_wr[row_count]   = wr;
        row_idx[row_count]  = idx;
        row_data[row_count] = data;
        row_count++;
    endtask

    // Index and data only matter for writers
    task automatic check_commit(input int r);
        assert (commit_wr === row_wr[r]) else begin
            errors++;
            $display("error %s: commit_wr expected %0b, actual %0b",
                     row_name[r], row_wr[r], commit_wr);
        end
        if (row_wr[r]) begin
            assert (commit_idx === row_idx[r]) else begin
                errors++;
                $display("error %s: commit_idx expected %0d, actual %0d",
                         row_name[r], row_idx[r], commit_idx);
            end
            assert (commit_data === row_data[r]) else begin
                errors++;
                $display("error %s: commit_data expected %h, actual %h",
                         row_name[r], row_data[r], commit_data);
            end
        end
    endtask

    task automatic build_table();
        // Every operation, x1 = 5 and x2 = -3
        add_row("addi",  enc_i(12'd5, 5'd0, 3'b000, 5'd1), 1, 5'd1, 32'd5);
        add_row("addi_neg", enc_i(12'hffd, 5'd0, 3'b000, 5'd2), 1, 5'd2, 32'hffff_fffd);
        add_row("add",   enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 1, 5'd3, 32'd2);
        add_row("sub",   enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4), 1, 5'd4, 32'd8);
        add_row("sll",   enc_r(7'h00, 5'd1, 5'd1, 3'b001, 5'd5), 1, 5'd5, 32'h0000_00a0);
        add_row("slt",   enc_r(7'h00, 5'd1, 5'd2, 3'b010, 5'd6), 1, 5'd6, 32'd1);
        add_row("sltu",  enc_r(7'h00, 5'd1, 5'd2, 3'b011, 5'd7), 1, 5'd7, 32'd0);
        add_row("xor",   enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd8), 1, 5'd8, 32'hffff_fff8);
        add_row("srl",   enc_r(7'h00, 5'd1, 5'd2, 3'b101, 5'd9), 1, 5'd9, 32'h07ff_ffff);
        add_row("sra",   enc_r(7'h20, 5'd1, 5'd2, 3'b101, 5'd10), 1, 5'd10, 32'hffff_ffff);
        add_row("or",    enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd11), 1, 5'd11, 32'hffff_fffd);
        add_row("and",   enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd12), 1, 5'd12, 32'd5);
        add_row("slli",  enc_i(12'd3, 5'd1, 3'b001, 5'd13), 1, 5'd13, 32'h0000_0028);
        add_row("slti",  enc_i(12'hffe, 5'd2, 3'b010, 5'd14), 1, 5'd14, 32'd1);
        add_row("sltiu", enc_i(12'd4, 5'd1, 3'b011, 5'd15), 1, 5'd15, 32'd0);
        add_row("xori",  enc_i(12'h0ff, 5'd1, 3'b100, 5'd16), 1, 5'd16, 32'h0000_00fa);
        add_row("srli",  enc_i(12'd28, 5'd2, 3'b101, 5'd17), 1, 5'd17, 32'h0000_000f);
        add_row("srai",  enc_i(12'h401, 5'd2, 3'b101, 5'd18), 1, 5'd18, 32'hffff_fffe);
        add_row("ori",   enc_i(12'h700, 5'd1, 3'b110, 5'd19), 1, 5'd19, 32'h0000_0705);
        add_row("andi",  enc_i(12'h0f0, 5'd2, 3'b111, 5'd20), 1, 5'd20, 32'h0000_00f0);
        // Back-to-back dependent chain
        add_row("chain_addi", enc_i(12'd1, 5'd20, 3'b000, 5'd21), 1, 5'd21, 32'h0000_00f1);
        add_row("chain_add",  enc_r(7'h00, 5'd21, 5'd21, 3'b000, 5'd22), 1, 5'd22, 32'h1e2);
        add_row("chain_sub",  enc_r(7'h20, 5'd21, 5'd22, 3'b000, 5'd23), 1, 5'd23, 32'h0f1);
        add_row("chain_slli", enc_i(12'd4, 5'd23, 3'b001, 5'd24), 1, 5'd24, 32'h0000_0f10);
        add_row("chain_xor",  enc_r(7'h00, 5'd23, 5'd24, 3'b100, 5'd25), 1, 5'd25, 32'hfe1);
        // Non-writing entries
        add_row("x0_target", enc_i(12'd7, 5'd1, 3'b000, 5'd0), 0, 5'd0, 32'd0);
        add_row("lui_nop",   32'h1234_52b7, 0, 5'd0, 32'd0);
        add_row("mul_nop",   enc_r(7'h01, 5'd1, 5'd1, 3'b000, 5'd28), 0, 5'd0, 32'd0);
        // x0 still reads zero
        add_row("x0_add",  enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd26), 1, 5'd26, 32'd0);
        add_row("x0_addi", enc_i(12'h123, 5'd0, 3'b000, 5'd27), 1, 5'd27, 32'h0000_0123);
        // 40 chained writers, targets cycle through x1 to x31
        for (int k = 0; k < 40; k++) begin
            add_row($sformatf("run_%0d", k),
                    enc_i(12'd3, (k == 0) ? 5'd0 : 5'((k - 1) % 31 + 1), 3'b000,
                          5'(k % 31 + 1)),
                    1, 5'(k % 31 + 1), 32'(3 * (k + 1)));
        end
        table_built = 1'b1;
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial begin
        bit taken;
        inst_valid = 1'b0;
        inst       = '0;
        build_table();
        @(posedge arst_n);
        #1;
        // Idle state right after reset
        assert (commit_valid === 1'b0 && commit_wr === 1'b0 && inst_ready === 1'b1) else begin
            errors++;
            $display("After reset the commit outputs are not low or inst_ready is not high");
        end
        @(negedge clock);
        for (int r = 0; r < row_count; r++) begin
            repeat (next_gap()) @(negedge clock);
            inst_valid = 1'b1;
            inst       = row_word[r];
            taken      = 1'b0;
            // Ready is stable until the next rising edge
            while (!taken) begin
                #1;
                taken = inst_ready;
                @(negedge clock);
            end
            inst_valid = 1'b0;
            inst       = '0;
        end
        wait (commits >= row_count);
        // Extra commits would show up here
        repeat (8) @(negedge clock);
        $display("Run closed with %0d errors, %0d assertion failures, %0d commits for %0d rows",
                 errors, uut.u_assertions.failures, commits, row_count);
        if (errors == 0 && uut.u_assertions.failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    //////////////////////////////
    // Commit checker
    //////////////////////////////

    // Commit outputs are registered, stable on the falling edge
    always @(negedge clock) begin
        if (arst_n && commit_valid) begin
            if (commits >= row_count) begin
                errors++;
                $display("An extra commit arrived after all %0d rows had committed", row_count);
            end else begin
                check_commit(commits);
            end
            commits++;
        end
    end

    // Watchdog
    initial begin
        wait (table_built);
        repeat (row_count * 30 + reset_cycles) @(posedge clock);
        $display("Timeout with only %0d of %0d commits seen, %0d errors before it",
                 commits, row_count, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- rename_pkg.sv
// Rename core shared definitions
package rename_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    // Datapath and register files
    localparam int xlen       = 32;
    localparam int arch_regs  = 32;
    localparam int arch_idx_w = 5;
    localparam int phys_regs  = 64;
    localparam int tag_w      = 6;

    // Reorder buffer
    localparam int rob_depth = 16;
    localparam int rob_idx_w = 4;

    //////////////////////////////
    // Encodings
    //////////////////////////////

    // Major opcodes handled by the core
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    // ALU operations
    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // Instruction word, register and immediate layouts
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [arch_idx_w-1:0] rs2;
            logic [arch_idx_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [arch_idx_w-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm12;
            logic [arch_idx_w-1:0] rs1;
            logic [2:0]            funct3;
            logic [arch_idx_w-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } inst_word_t;

endpackage

//--- rob.sv
// Reorder buffer
module rob (
    input  logic                              clock,
    input  logic                              arst_n,
    input  logic                              alloc_en, alloc_wr,
    input  logic [rename_pkg::arch_idx_w-1:0] alloc_idx,
    input  logic [rename_pkg::tag_w-1:0]      alloc_tag, alloc_old_tag,
    output logic                              rob_full,
    output logic [rename_pkg::rob_idx_w-1:0]  rob_tail_idx,
    input  logic                              cdb_en,
    input  logic [rename_pkg::rob_idx_w-1:0]  cdb_rob_idx,
    output logic [rename_pkg::tag_w-1:0]      retire_tag,
    input  logic [rename_pkg::xlen-1:0]       retire_data,
    output logic                              free_en,
    output logic [rename_pkg::tag_w-1:0]      free_tag,
    output logic                              commit_valid, commit_wr,
    output logic [rename_pkg::arch_idx_w-1:0] commit_idx,
    output logic [rename_pkg::xlen-1:0]       commit_data
);

    // Per-entry state
    logic [rename_pkg::rob_depth-1:0]  done, wr;
    logic [rename_pkg::arch_idx_w-1:0] idx_q [rename_pkg::rob_depth];
    logic [rename_pkg::tag_w-1:0]      tag_q [rename_pkg::rob_depth];
    logic [rename_pkg::tag_w-1:0]      old_q [rename_pkg::rob_depth];

    logic [rename_pkg::rob_idx_w-1:0] head, tail;
    logic [rename_pkg::rob_idx_w:0]   count;
    logic                             retire;

    assign rob_full     = count == rename_pkg::rob_depth;
    assign rob_tail_idx = tail;

    // Head leaves once its result is on the bus
    assign retire     = count != '0 && done[head];
    assign retire_tag = tag_q[head];
    assign free_en    = retire && wr[head];
    assign free_tag   = old_q[head];

    //////////////////////////////
    // Pointers and completion
    //////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (alloc_en) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            // One edge after the broadcast
            if (cdb_en) begin
                done[cdb_rob_idx] <= 1'b1;
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            count <= count + (rename_pkg::rob_idx_w + 1)'(alloc_en)
                           - (rename_pkg::rob_idx_w + 1)'(retire);
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        if (alloc_en) begin
            wr[tail]    <= alloc_wr;
            idx_q[tail] <= alloc_idx;
            tag_q[tail] <= alloc_tag;
            old_q[tail] <= alloc_old_tag;
        end
    end

    //////////////////////////////
    // Commit outputs
    //////////////////////////////

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            commit_valid <= 1'b0;
            commit_wr    <= 1'b0;
        end else begin
            commit_valid <= retire;
            commit_wr    <= free_en;
        end
    end

    // Non-writers report zero data
    always_ff @(posedge clock) begin
        if (retire) begin
            commit_idx  <= idx_q[head];
            commit_data <= wr[head] ? retire_data : '0;
        end
    end

endmodule

//--- tb.f
rename_pkg.sv
dispatch.sv
map_table.sv
free_list.sv
rob.sv
prf.sv
alu_pipe.sv
rename_core.sv
tb_clock.sv
rename_core_assertions.sv
rename_core_tb.sv

//--- tb_clock.sv
// Testbench clock and reset
module tb_clock (
    output logic clock,
    output logic arst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 20 ns period, first rise at 10 ns
    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Reset held for 4 cycles, released on a falling edge
    initial begin
        arst_n = 1'b0;
        repeat (4) @(negedge clock);
        arst_n = 1'b1;
    end

endmodule
